/* compile.f */
rtl/cache_pkg.sv
rtl/cache_mem_if.sv
rtl/cache_way.sv
rtl/cache_ctrl.sv
rtl/cache_2way.sv
verification/mem_model.sv
verification/tb_cache_2way.sv

/* rtl/cache_2way.sv */
`timescale 1ns/100ps

module cache_2way #(
	parameter int WIDTH = 128,
	parameter int DEPTH = 4,
	localparam int BYTES = WIDTH / 8
) (
	input  logic             clk,
	input  logic             reset,
	input  cache_pkg::addr_t addr,
	input  logic             read_write,
	input  logic             master_enable,
	input  logic [BYTES-1:0] byte_enable,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out,
	output logic             hit,
	output logic             mem_write_req,
	output cache_pkg::addr_t mem_write_addr,
	output logic [WIDTH-1:0] mem_write_data,
	input  logic             mem_write_ack,
	output logic             mem_read_req,
	output cache_pkg::addr_t mem_read_addr,
	input  logic [WIDTH-1:0] mem_read_data,
	input  logic             mem_read_ack
);

	localparam int OFF_W = $clog2(BYTES);
	localparam int IDX_W = $clog2(DEPTH);
	localparam int TAG_W = cache_pkg::ADDR_W - OFF_W - IDX_W;

	logic [1:0]            way_hit;
	logic [1:0]            line_valid;
	logic [1:0]            line_dirty;
	logic [1:0][TAG_W-1:0] line_tag;
	logic [1:0][WIDTH-1:0] line_data;
	logic [1:0]            fill_en;
	logic [1:0]            clear_valid;
	logic [1:0]            way_we;
	cache_pkg::addr_t      fill_addr;
	logic [WIDTH-1:0]      sel_line;
	logic [WIDTH-1:0]      merged;
	logic                  is_read;

	cache_mem_if #(.WIDTH(WIDTH)) mem_if ();

	assign hit     = |way_hit;
	assign is_read = (read_write == cache_pkg::OP_READ);

	for (genvar w = 0; w < 2; w++) begin : g_way
		assign way_we[w] = master_enable && !is_read && way_hit[w];

		cache_way #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_way (
			.clk         (clk),
			.reset       (reset),
			.addr        (addr),
			.byte_enable (byte_enable),
			.data_in     (data_in),
			.write_en    (way_we[w]),
			.fill_en     (fill_en[w]),
			.fill_addr   (fill_addr),
			.fill_data   (mem_if.read_data),
			.clear_valid (clear_valid[w]),
			.way_hit     (way_hit[w]),
			.line_valid  (line_valid[w]),
			.line_dirty  (line_dirty[w]),
			.line_tag    (line_tag[w]),
			.line_data   (line_data[w])
		);
	end

	cache_ctrl #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.master_enable (master_enable),
		.addr          (addr),
		.way_hit       (way_hit),
		.line_valid    (line_valid),
		.line_dirty    (line_dirty),
		.line_tag      (line_tag),
		.line_data     (line_data),
		.fill_en       (fill_en),
		.clear_valid   (clear_valid),
		.fill_addr     (fill_addr),
		.mem           (mem_if.ctrl)
	);

	// Read data shows the line as it stands after a write
	assign sel_line = way_hit[1] ? line_data[1] : line_data[0];

	always_comb begin
		for (int b = 0; b < BYTES; b++) begin
			merged[8*b +: 8] = byte_enable[b] ? data_in[8*b +: 8] : sel_line[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			data_out <= '0;
		else if (master_enable && hit)
			data_out <= is_read ? sel_line : merged; // Held until the next commit
	end

	// Memory side of the interface onto plain ports
	assign mem_write_req    = mem_if.write_req;
	assign mem_write_addr   = mem_if.write_addr;
	assign mem_write_data   = mem_if.write_data;
	assign mem_if.write_ack = mem_write_ack;
	assign mem_read_req     = mem_if.read_req;
	assign mem_read_addr    = mem_if.read_addr;
	assign mem_if.read_data = mem_read_data;
	assign mem_if.read_ack  = mem_read_ack;

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/100ps

module cache_ctrl #(
	parameter int WIDTH = 128,
	parameter int DEPTH = 4,
	localparam int BYTES = WIDTH / 8,
	localparam int OFF_W = $clog2(BYTES),
	localparam int IDX_W = $clog2(DEPTH),
	localparam int TAG_W = cache_pkg::ADDR_W - OFF_W - IDX_W
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  master_enable,
	input  cache_pkg::addr_t      addr,
	input  logic [1:0]            way_hit,
	input  logic [1:0]            line_valid,
	input  logic [1:0]            line_dirty,
	input  logic [1:0][TAG_W-1:0] line_tag,
	input  logic [1:0][WIDTH-1:0] line_data,
	output logic [1:0]            fill_en,
	output logic [1:0]            clear_valid,
	output cache_pkg::addr_t      fill_addr,
	cache_mem_if.ctrl             mem
);

	cache_pkg::ctrl_state_e state;

	logic [DEPTH-1:0] lru; // Names the least recently used way per index
	logic [IDX_W-1:0] idx;
	logic             any_hit;
	logic             take;
	logic             victim;
	logic             victim_next;
	logic             victim_dirty;

	assign idx     = addr[OFF_W +: IDX_W];
	assign any_hit = |way_hit;

	// Start a miss only from IDLE, one outstanding at a time
	assign take = (state == cache_pkg::IDLE) && master_enable && !any_hit;

	// Invalid way 0, then invalid way 1, else LRU
	always_comb begin
		if (!line_valid[0])
			victim_next = 1'b0;
		else if (!line_valid[1])
			victim_next = 1'b1;
		else
			victim_next = lru[idx];
	end

	assign victim_dirty = line_valid[victim_next] && line_dirty[victim_next];

	always_comb begin
		clear_valid = 2'b00;
		fill_en     = 2'b00;
		clear_valid[victim_next] = take && victim_dirty;
		fill_en[victim] = (state == cache_pkg::FILL) && mem.read_ack; // Line lands on the ack edge
	end

	assign fill_addr = mem.read_addr;

	// Point away from the way just used on every committed hit
	always_ff @(posedge clk) begin
		if (reset)
			lru <= '0;
		else if (master_enable && any_hit)
			lru[idx] <= way_hit[0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= cache_pkg::IDLE;
			victim         <= 1'b0;
			mem.write_req  <= 1'b0;
			mem.write_addr <= '0;
			mem.read_req   <= 1'b0;
			mem.read_addr  <= '0;
		end else begin
			case (state)
				cache_pkg::IDLE: begin
					if (take) begin
						victim        <= victim_next;
						mem.read_addr <= {addr[cache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
						if (victim_dirty) begin
							mem.write_addr <= {line_tag[victim_next], idx, {OFF_W{1'b0}}};
							mem.write_req  <= 1'b1;
							state          <= cache_pkg::WRITE_BACK;
						end else begin
							state <= cache_pkg::FILL;
						end
					end
				end
				cache_pkg::WRITE_BACK: begin
					// Request held until memory takes the line
					if (mem.write_ack) begin
						mem.write_req <= 1'b0;
						state         <= cache_pkg::FILL;
					end
				end
				cache_pkg::FILL: begin
					if (mem.read_ack) begin
						mem.read_req <= 1'b0;
						state        <= cache_pkg::DONE;
					end else begin
						mem.read_req <= 1'b1; // Rises one cycle into FILL
					end
				end
				cache_pkg::DONE: begin
					state <= cache_pkg::IDLE; // Host commits on the hit here
				end
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	// Victim line captured for write-back
	always_ff @(posedge clk) begin
		if (take && victim_dirty)
			mem.write_data <= line_data[victim_next];
	end

endmodule

/* rtl/cache_mem_if.sv */
`timescale 1ns/100ps

interface cache_mem_if #(
	parameter int WIDTH = 128
);
	// Write-back channel
	logic             write_req;
	cache_pkg::addr_t write_addr;
	logic [WIDTH-1:0] write_data;
	logic             write_ack;

	// Fill channel
	logic             read_req;
	cache_pkg::addr_t read_addr;
	logic [WIDTH-1:0] read_data;
	logic             read_ack;

	modport ctrl (
		output write_req, write_addr, write_data,
		input  write_ack,
		output read_req, read_addr,
		input  read_data, read_ack
	);

	modport mem (
		input  write_req, write_addr, write_data,
		output write_ack,
		input  read_req, read_addr,
		output read_data, read_ack
	);

endinterface

/* rtl/cache_pkg.sv */
package cache_pkg;

	// Host byte address
	localparam int ADDR_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;

	// Encoding follows read_write, 1 means read
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} cache_op_e;

	// Miss sequencing
	typedef enum logic [1:0] {
		IDLE,       // Waiting for a miss
		WRITE_BACK, // Dirty victim going out
		FILL,       // New line coming in
		DONE        // Line in place, host sees hit
	} ctrl_state_e;

endpackage

/* rtl/cache_way.sv */
`timescale 1ns/100ps

module cache_way #(
	parameter int WIDTH = 128,
	parameter int DEPTH = 4,
	localparam int BYTES = WIDTH / 8,
	localparam int OFF_W = $clog2(BYTES),
	localparam int IDX_W = $clog2(DEPTH),
	localparam int TAG_W = cache_pkg::ADDR_W - OFF_W - IDX_W
) (
	input  logic             clk,
	input  logic             reset,
	input  cache_pkg::addr_t addr,
	input  logic [BYTES-1:0] byte_enable,
	input  logic [WIDTH-1:0] data_in,
	input  logic             write_en,
	input  logic             fill_en,
	input  cache_pkg::addr_t fill_addr,
	input  logic [WIDTH-1:0] fill_data,
	input  logic             clear_valid,
	output logic             way_hit,
	output logic             line_valid,
	output logic             line_dirty,
	output logic [TAG_W-1:0] line_tag,
	output logic [WIDTH-1:0] line_data
);

	logic [DEPTH-1:0] valid;
	logic [DEPTH-1:0] dirty;
	logic [TAG_W-1:0] tags  [DEPTH];
	logic [WIDTH-1:0] lines [DEPTH];

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;
	logic [WIDTH-1:0] merged;

	// Offset bits are not used, whole lines move
	assign idx      = addr[OFF_W +: IDX_W];
	assign tag      = addr[cache_pkg::ADDR_W-1 -: TAG_W];
	assign fill_idx = fill_addr[OFF_W +: IDX_W];
	assign fill_tag = fill_addr[cache_pkg::ADDR_W-1 -: TAG_W];

	assign line_valid = valid[idx];
	assign line_dirty = dirty[idx];
	assign line_tag   = tags[idx];
	assign line_data  = lines[idx];
	assign way_hit    = line_valid && (line_tag == tag);

	// Byte merge of host data into the stored line
	always_comb begin
		for (int b = 0; b < BYTES; b++) begin
			merged[8*b +: 8] = byte_enable[b] ? data_in[8*b +: 8] : line_data[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (clear_valid)
				valid[idx] <= 1'b0; // Victim on its way out
			if (write_en)
				dirty[idx] <= 1'b1;
			if (fill_en) begin
				valid[fill_idx] <= 1'b1;
				dirty[fill_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_en)
			lines[idx] <= merged;
		if (fill_en) begin
			lines[fill_idx] <= fill_data;
			tags[fill_idx]  <= fill_tag;
		end
	end

endmodule

/* verification/cache_trace.txt */
# name op(1=read,0=write) addr byte_enable data exp_data exp_hit wb wb_addr wb_line
# hex fields, unused ones 0; wb=1 expects one write-back of wb_line to wb_addr before the fill
rd_miss 1 00001014 0 0 00001010000010100000101000001010 0 0 0 0
rd_hit 1 00001018 0 0 00001010000010100000101000001010 1 0 0 0
rd_way1_miss 1 00002010 0 0 00002010000020100000201000002010 0 0 0 0
rd_way1_hit 1 0000201c 0 0 00002010000020100000201000002010 1 0 0 0
rd_way0_hit 1 00001010 0 0 00001010000010100000101000001010 1 0 0 0
wr_partial 0 00001010 0306 112233445566778899aabbccddeeff00 00001010000077880000101000eeff10 1 0 0 0
rd_merged 1 00001010 0 0 00001010000077880000101000eeff10 1 0 0 0
rd_way1_again 1 00002010 0 0 00002010000020100000201000002010 1 0 0 0
rd_evict 1 00003010 0 0 00003010000030100000301000003010 0 1 00001010 00001010000077880000101000eeff10
rd_recent 1 00002014 0 0 00002010000020100000201000002010 1 0 0 0
rd_refetch 1 00001010 0 0 00001010000077880000101000eeff10 0 0 0 0
wr_miss 0 00000520 ffff 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 0 0 0 0
rd_after_wr 1 0000052c 0 0 0123456789abcdeffedcba9876543210 1 0 0 0
wr_miss_way1 0 00004020 f000 deadbeef000000000000000000000000 deadbeef000040200000402000004020 0 0 0 0
rd_evict2 1 00005020 0 0 00005020000050200000502000005020 0 1 00000520 0123456789abcdeffedcba9876543210
rd_dirty_way1 1 00004024 0 0 deadbeef000040200000402000004020 1 0 0 0

/* verification/mem_model.sv */
`timescale 1ns/100ps

module mem_model #(
	parameter int WIDTH = 128,
	parameter int SEED  = 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             write_req,
	input  cache_pkg::addr_t write_addr,
	input  logic [WIDTH-1:0] write_data,
	output logic             write_ack,
	input  logic             read_req,
	input  cache_pkg::addr_t read_addr,
	output logic [WIDTH-1:0] read_data,
	output logic             read_ack
);

	// Log of every write-back, in arrival order
	cache_pkg::addr_t wb_addr [$];
	logic [WIDTH-1:0] wb_line [$];
	int               wr_wait;
	int               rd_wait;

	// Lines never written back hold their own address in every word
	function automatic logic [WIDTH-1:0] line_at(input cache_pkg::addr_t a);
		logic [WIDTH-1:0] l;
		l = {(WIDTH/32){a}};
		foreach (wb_addr[i])
			if (wb_addr[i] == a)
				l = wb_line[i]; // Latest write-back wins
		return l;
	endfunction

	// One process so the seed covers every latency draw
	initial begin
		void'($urandom(SEED));
		write_ack = 1'b0;
		read_ack  = 1'b0;
		read_data = '0;
		wr_wait   = 0;
		rd_wait   = 0;
		forever begin
			@(negedge clk);
			write_ack <= 1'b0;
			read_ack  <= 1'b0;
			if (reset) begin
				wr_wait = 0;
				rd_wait = 0;
			end else begin
				if (write_req && !write_ack) begin
					if (wr_wait == 0)
						wr_wait = 1 + $urandom % 6;
					if (wr_wait == 1) begin
						wb_addr.push_back(write_addr);
						wb_line.push_back(write_data);
						write_ack <= 1'b1;
					end
					wr_wait = wr_wait - 1;
				end
				if (read_req && !read_ack) begin
					if (rd_wait == 0)
						rd_wait = 1 + $urandom % 6;
					if (rd_wait == 1) begin
						read_data <= line_at(read_addr);
						read_ack  <= 1'b1; // One-cycle pulse
					end
					rd_wait = rd_wait - 1;
				end
			end
		end
	end

endmodule

/* verification/tb_cache_2way.sv */
`timescale 1ns/100ps

module tb_cache_2way;

	localparam int WIDTH = 128;
	localparam int DEPTH = 4;
	localparam int BYTES = WIDTH / 8;

	logic             clk;
	logic             reset;
	cache_pkg::addr_t addr;
	logic             read_write;
	logic             master_enable;
	logic [BYTES-1:0] byte_enable;
	logic [WIDTH-1:0] data_in;
	logic [WIDTH-1:0] data_out;
	logic             hit;
	logic             mem_write_req;
	cache_pkg::addr_t mem_write_addr;
	logic [WIDTH-1:0] mem_write_data;
	logic             mem_write_ack;
	logic             mem_read_req;
	cache_pkg::addr_t mem_read_addr;
	logic [WIDTH-1:0] mem_read_data;
	logic             mem_read_ack;

	// Trace columns
	string                t_name    [$];
	cache_pkg::cache_op_e t_op      [$];
	cache_pkg::addr_t     t_addr    [$];
	logic [BYTES-1:0]     t_be      [$];
	logic [WIDTH-1:0]     t_data    [$];
	logic [WIDTH-1:0]     t_exp     [$];
	logic                 t_hit     [$];
	logic                 t_wb      [$];
	cache_pkg::addr_t     t_wb_addr [$];
	logic [WIDTH-1:0]     t_wb_line [$];

	// Memory traffic seen at the DUT ports
	int               val_errors   = 0;
	int               other_errors = 0;
	int               cycle        = 0;
	int               rd_count     = 0;
	int               rd_cycle     = 0;
	int               wb_cycle     = 0;
	cache_pkg::addr_t rd_addr_last = '0;
	cache_pkg::addr_t wb_addr_log [$];
	logic [WIDTH-1:0] wb_line_log [$];
	logic             wr_req_q;
	logic             wr_ack_q;
	logic             rd_req_q;
	logic             rd_ack_q;

	cache_2way #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_dut (
		.clk            (clk),
		.reset          (reset),
		.addr           (addr),
		.read_write     (read_write),
		.master_enable  (master_enable),
		.byte_enable    (byte_enable),
		.data_in        (data_in),
		.data_out       (data_out),
		.hit            (hit),
		.mem_write_req  (mem_write_req),
		.mem_write_addr (mem_write_addr),
		.mem_write_data (mem_write_data),
		.mem_write_ack  (mem_write_ack),
		.mem_read_req   (mem_read_req),
		.mem_read_addr  (mem_read_addr),
		.mem_read_data  (mem_read_data),
		.mem_read_ack   (mem_read_ack)
	);

	mem_model #(.WIDTH(WIDTH), .SEED(57980)) u_mem (
		.clk        (clk),
		.reset      (reset),
		.write_req  (mem_write_req),
		.write_addr (mem_write_addr),
		.write_data (mem_write_data),
		.write_ack  (mem_write_ack),
		.read_req   (mem_read_req),
		.read_addr  (mem_read_addr),
		.read_data  (mem_read_data),
		.read_ack   (mem_read_ack)
	);

	always #4 clk = ~clk;

	task automatic check_line(input string name, input logic [WIDTH-1:0] exp,
			input logic [WIDTH-1:0] act);
		if (act !== exp) begin
			val_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input cache_pkg::addr_t exp,
			input cache_pkg::addr_t act);
		if (act !== exp) begin
			val_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			val_errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Protocol watch and traffic log sampled before the edge takes effect
	always @(posedge clk) begin
		cycle++;
		if (!reset) begin
			if (mem_read_req && mem_write_req) begin
				other_errors++;
				$display("Protocol fault: read_req raised while write_req is high");
			end
			if (wr_req_q && !wr_ack_q && !mem_write_req) begin
				other_errors++;
				$display("Protocol fault: write_req dropped before write_ack");
			end
			if (rd_req_q && !rd_ack_q && !mem_read_req) begin
				other_errors++;
				$display("Protocol fault: read_req dropped before read_ack");
			end
			if (mem_write_req && mem_write_ack) begin
				wb_addr_log.push_back(mem_write_addr);
				wb_line_log.push_back(mem_write_data);
				wb_cycle = cycle;
			end
			if (mem_read_req && mem_read_ack) begin
				rd_count++;
				rd_addr_last = mem_read_addr;
				rd_cycle     = cycle;
			end
		end
		wr_req_q = mem_write_req;
		wr_ack_q = mem_write_ack;
		rd_req_q = mem_read_req;
		rd_ack_q = mem_read_ack;
	end

	task automatic read_trace();
		int               fd;
		int               n;
		int               op;
		string            line;
		string            name;
		cache_pkg::addr_t a;
		logic [BYTES-1:0] be;
		logic [WIDTH-1:0] d;
		logic [WIDTH-1:0] e;
		logic             h;
		logic             w;
		cache_pkg::addr_t wa;
		logic [WIDTH-1:0] wl;
		fd = $fopen("verification/cache_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the trace file verification/cache_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h",
						name, op, a, be, d, e, h, w, wa, wl);
					if (n == 10) begin
						t_name.push_back(name);
						t_op.push_back(op[0] ? cache_pkg::OP_READ : cache_pkg::OP_WRITE);
						t_addr.push_back(a);
						t_be.push_back(be);
						t_data.push_back(d);
						t_exp.push_back(e);
						t_hit.push_back(h);
						t_wb.push_back(w);
						t_wb_addr.push_back(wa);
						t_wb_line.push_back(wl);
					end else begin
						other_errors++;
						$display("Malformed trace line: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic watchdog(input int entries);
		repeat (entries * 40 + 16) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", entries * 40 + 16);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic run_entry(input int i);
		int               rd_start;
		int               wb_start;
		cache_pkg::addr_t line_addr;
		line_addr = t_addr[i] & ~cache_pkg::addr_t'(BYTES - 1); // Offset dropped
		@(negedge clk);
		addr          <= t_addr[i];
		read_write    <= t_op[i];
		byte_enable   <= t_be[i];
		data_in       <= t_data[i];
		master_enable <= 1'b1;
		rd_start = rd_count;
		wb_start = wb_addr_log.size();
		@(posedge clk);
		check_flag({t_name[i], " first-cycle hit"}, t_hit[i], hit);
		while (!hit)
			@(posedge clk); // Miss ends when hit shows up
		@(negedge clk);
		master_enable <= 1'b0;
		check_line({t_name[i], " data_out"}, t_exp[i], data_out);
		check_flag({t_name[i], " read issued"}, !t_hit[i], rd_count != rd_start);
		if (!t_hit[i])
			check_addr({t_name[i], " read address"}, line_addr, rd_addr_last);
		check_flag({t_name[i], " write-back issued"}, t_wb[i], wb_addr_log.size() != wb_start);
		if (t_wb[i] && wb_addr_log.size() > wb_start) begin
			check_addr({t_name[i], " write-back address"}, t_wb_addr[i], wb_addr_log[wb_start]);
			check_line({t_name[i], " write-back line"}, t_wb_line[i], wb_line_log[wb_start]);
			if (wb_cycle > rd_cycle) begin
				other_errors++;
				$display("%s: the write-back finished after the fill", t_name[i]);
			end
		end
		if (rd_count - rd_start > 1 || wb_addr_log.size() - wb_start > 1) begin
			other_errors++;
			$display("%s: more than one memory transfer of a kind for one access", t_name[i]);
		end
	endtask

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		addr          = '0;
		read_write    = 1'b1;
		master_enable = 1'b0;
		byte_enable   = '0;
		data_in       = '0;
		read_trace();
		if (t_name.size() == 0) begin
			other_errors++;
			$display("The trace holds no entries");
		end
		fork
			watchdog(t_name.size());
		join_none
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_flag("reset write_req", 1'b0, mem_write_req);
		check_flag("reset read_req", 1'b0, mem_read_req);
		// Empty cache misses everywhere
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			addr <= cache_pkg::addr_t'(i) * 32'h0101_0110;
			@(posedge clk);
			check_flag("reset hit", 1'b0, hit);
		end
		for (int i = 0; i < t_name.size(); i++)
			run_entry(i);
		repeat (2) @(posedge clk);
		check_flag("idle write_req", 1'b0, mem_write_req);
		check_flag("idle read_req", 1'b0, mem_read_req);
		$display("Errors: %0d value mismatches, %0d protocol or other faults",
			val_errors, other_errors);
		if (val_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
